//--- txbist_cfg.svh
`ifndef TXBIST_CFG_SVH
`define TXBIST_CFG_SVH

// widths and depths
`define TXBIST_RAM_AW       10
`define TXBIST_FIFO_DEPTH   8
`define APB_AW              8

// control byte codes
`define TXBIST_REPEAT_OP    8'h55  // ctl byte of a repeat word
`define TXBIST_EOF_CODE     8'hFD  // counted only with its K bit set
`define TXBIST_IDLE_CTL     8'hFF
`define TXBIST_PRIM_CTL     8'hFF

// --------------------------------------------------------------------
// APB register map, byte offsets
// --------------------------------------------------------------------
`define TXBIST_REG_CTRL       8'h00  // [1:0] mode
`define TXBIST_REG_LOOP_CNT   8'h04  // 0 means forever
`define TXBIST_REG_RAM_END    8'h08
`define TXBIST_REG_PRIM_LO    8'h0C
`define TXBIST_REG_PRIM_HI    8'h10
`define TXBIST_REG_IDLE_LO    8'h14
`define TXBIST_REG_IDLE_HI    8'h18
`define TXBIST_REG_WR_ADDR    8'h1C
`define TXBIST_REG_WR_DATA_LO 8'h20
`define TXBIST_REG_WR_DATA_HI 8'h24
`define TXBIST_REG_WR_CTL     8'h28  // write launches the RAM write
`define TXBIST_REG_RD_ADDR    8'h2C  // write launches the RAM read
`define TXBIST_REG_RD_DATA_LO 8'h30
`define TXBIST_REG_RD_DATA_HI 8'h34
`define TXBIST_REG_RD_CTL     8'h38
`define TXBIST_REG_FRAME_CNT  8'h3C  // any write clears

`endif

//--- txbist_pkg.sv
`include "txbist_cfg.svh"

package txbist_pkg;

  typedef logic [`TXBIST_RAM_AW-1:0] ram_addr_t;
  typedef logic [7:0]                ctl_t;       // one K flag per byte
  typedef logic [63:0]               data_t;
  typedef logic [31:0]               loop_cnt_t;
  typedef logic [31:0]               apb_word_t;

  typedef enum logic [1:0]
  {
    DISABLED = 2'd0,
    RAM      = 2'd1,
    PRIM     = 2'd2
  } bist_mode_e;

  typedef enum logic [1:0]
  {
    SEQ_IDLE,
    SEQ_START,
    SEQ_FETCH,
    SEQ_DONE
  } seq_state_e;

  // --------------------------------------------------------------------
  // bundles
  // --------------------------------------------------------------------
  typedef struct packed
  {
    ctl_t  ctl;
    data_t data;
  } tx_word_t;

  typedef struct packed
  {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [`APB_AW-1:0]  paddr;
    apb_word_t           pwdata;
  } apb_req_t;

  typedef struct packed
  {
    apb_word_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed
  {
    bist_mode_e mode;
    loop_cnt_t  loop_cnt;
    ram_addr_t  ram_end;
    tx_word_t   prim;
    tx_word_t   idle;
  } bist_cfg_t;

  typedef struct packed
  {
    logic      req;
    logic      we;
    ram_addr_t addr;
    tx_word_t  wdata;
  } mem_req_t;

endpackage

//--- txbist_fifo.sv
`timescale 1ns/1ns

module txbist_fifo import txbist_pkg::*;
#(
  parameter int DEPTH = 8
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     clear,
  input  logic     push,
  input  tx_word_t push_data,
  input  logic     pop,
  output tx_word_t pop_data,
  output logic     empty
);

  localparam int AW = $clog2(DEPTH);

  tx_word_t    mem [DEPTH];
  logic [AW:0] wptr;  // extra bit tells full from empty
  logic [AW:0] rptr;

  assign empty    = (wptr == rptr);
  assign pop_data = mem[rptr[AW-1:0]];  // show-ahead read

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wptr[AW-1:0]] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else if (clear)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      if (push)
        wptr <= wptr + 1'b1;
      if (pop && !empty)
        rptr <= rptr + 1'b1;
    end
  end

endmodule

//--- txbist_mem_arb.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module txbist_mem_arb import txbist_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mem_req_t  reg_req,
  output logic      reg_gnt,
  output logic      reg_rvalid,
  input  logic      fetch_req,
  input  ram_addr_t fetch_addr,
  output logic      fetch_gnt,
  output logic      fetch_rvalid,
  output tx_word_t  rdata
);

  localparam int WORDS = 1 << `TXBIST_RAM_AW;

  tx_word_t  ram [WORDS];  // pattern RAM, single port
  ram_addr_t rd_addr;
  logic      rd_en;

  // register port always wins, fetch waits
  assign reg_gnt   = reg_req.req;
  assign fetch_gnt = fetch_req & ~reg_req.req;

  assign rd_en   = (reg_gnt & ~reg_req.we) | fetch_gnt;
  assign rd_addr = reg_gnt ? reg_req.addr : fetch_addr;

  always_ff @(posedge clk)
  begin
    if (reg_gnt && reg_req.we)
      ram[reg_req.addr] <= reg_req.wdata;
    if (rd_en)
      rdata <= ram[rd_addr];  // one cycle after grant
  end

  // valid goes back to whichever side won
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_rvalid   <= 1'b0;
      fetch_rvalid <= 1'b0;
    end
    else
    begin
      reg_rvalid   <= reg_gnt & ~reg_req.we;
      fetch_rvalid <= fetch_gnt;
    end
  end

endmodule

//--- txbist_out.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module txbist_out import txbist_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  bist_cfg_t cfg,
  output logic      pop,
  input  tx_word_t  pop_data,
  input  logic      empty,
  output logic      tx_val,
  output tx_word_t  tx_word,
  output logic      eof
);

  logic [31:0] rpt_cnt;  // held-word cycles still to send
  tx_word_t    held;     // last word sent from the FIFO
  tx_word_t    next_word;
  logic        ram_mode;
  logic        is_op;
  logic        eof_hit;

  assign ram_mode = (cfg.mode == RAM);
  assign pop      = ram_mode && !empty && (rpt_cnt == '0);
  assign is_op    = (pop_data.ctl == `TXBIST_REPEAT_OP);

  // --------------------------------------------------------------------
  // word select
  // --------------------------------------------------------------------
  always_comb
  begin
    if (cfg.mode == PRIM)
      next_word = cfg.prim;
    else if (rpt_cnt != '0)
      next_word = held;
    else if (pop && !is_op)
      next_word = pop_data;
    else
      next_word = cfg.idle;  // also covers the opcode slot
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_val  <= 1'b0;
      rpt_cnt <= '0;
    end
    else
    begin
      tx_val <= 1'b1;
      if (!ram_mode)
        rpt_cnt <= '0;
      else if (pop && is_op)
        rpt_cnt <= pop_data.data[31:0];
      else if (rpt_cnt != '0)
        rpt_cnt <= rpt_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    tx_word <= next_word;
    if (pop && !is_op)
      held <= pop_data;
  end

  // end of frame on the word now on the wire
  always_comb
  begin
    eof_hit = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      if (tx_word.ctl[i] && tx_word.data[8*i +: 8] == `TXBIST_EOF_CODE)
        eof_hit = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      eof <= 1'b0;
    else
      eof <= tx_val & eof_hit;  // tx_word undefined before first edge
  end

endmodule

//--- txbist_regs.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module txbist_regs import txbist_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  output bist_cfg_t cfg,
  output mem_req_t  mem_req,
  input  logic      mem_gnt,
  input  logic      mem_rvalid,
  input  tx_word_t  mem_rdata,
  input  logic      eof
);

  bist_mode_e         mode;
  loop_cnt_t          loop_cnt;
  ram_addr_t          ram_end;
  apb_word_t          prim_lo;
  apb_word_t          prim_hi;
  apb_word_t          idle_lo;
  apb_word_t          idle_hi;
  ram_addr_t          wr_addr;    // auto-increments per WR_CTL write
  apb_word_t          wr_data_lo;
  apb_word_t          wr_data_hi;
  apb_word_t          frame_cnt;
  tx_word_t           rd_word;    // readback holding register
  logic               acc_busy;   // RAM request waiting for grant
  logic               rd_wait;    // granted read, data not back yet
  logic               acc_we;
  ram_addr_t          acc_addr;
  tx_word_t           acc_wdata;
  logic [`APB_AW-1:0] addr;
  logic               apb_wr;
  logic               launch_wr;
  logic               launch_rd;

  assign addr      = apb_req.paddr;
  assign apb_wr    = apb_req.psel & apb_req.penable & apb_req.pwrite & ~acc_busy & ~rd_wait;
  assign launch_wr = apb_wr & (addr == `TXBIST_REG_WR_CTL);
  assign launch_rd = apb_wr & (addr == `TXBIST_REG_RD_ADDR);

  // --------------------------------------------------------------------
  // configuration registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mode       <= DISABLED;
      loop_cnt   <= 32'd1;
      ram_end    <= '0;
      prim_lo    <= '0;
      prim_hi    <= '0;
      idle_lo    <= 32'h0707_0707;
      idle_hi    <= 32'h0707_0707;
      wr_addr    <= '0;
      wr_data_lo <= '0;
      wr_data_hi <= '0;
    end
    else if (apb_wr)
    begin
      case (addr)
        `TXBIST_REG_CTRL:       mode <= (apb_req.pwdata[1:0] == 2'd3) ? DISABLED :
                                        bist_mode_e'(apb_req.pwdata[1:0]);
        `TXBIST_REG_LOOP_CNT:   loop_cnt   <= apb_req.pwdata;
        `TXBIST_REG_RAM_END:    ram_end    <= apb_req.pwdata[`TXBIST_RAM_AW-1:0];
        `TXBIST_REG_PRIM_LO:    prim_lo    <= apb_req.pwdata;
        `TXBIST_REG_PRIM_HI:    prim_hi    <= apb_req.pwdata;
        `TXBIST_REG_IDLE_LO:    idle_lo    <= apb_req.pwdata;
        `TXBIST_REG_IDLE_HI:    idle_hi    <= apb_req.pwdata;
        `TXBIST_REG_WR_ADDR:    wr_addr    <= apb_req.pwdata[`TXBIST_RAM_AW-1:0];
        `TXBIST_REG_WR_DATA_LO: wr_data_lo <= apb_req.pwdata;
        `TXBIST_REG_WR_DATA_HI: wr_data_hi <= apb_req.pwdata;
        `TXBIST_REG_WR_CTL:     wr_addr    <= wr_addr + 1'b1;  // next RAM word
        default: ;
      endcase
    end
  end

  // RAM access wait states
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_busy <= 1'b0;
      rd_wait  <= 1'b0;
      acc_we   <= 1'b0;
    end
    else
    begin
      if (launch_wr | launch_rd)
      begin
        acc_busy <= 1'b1;
        acc_we   <= launch_wr;
      end
      else if (mem_gnt)
        acc_busy <= 1'b0;
      if (acc_busy & mem_gnt & ~acc_we)
        rd_wait <= 1'b1;
      else if (mem_rvalid)
        rd_wait <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch_wr | launch_rd)
    begin
      acc_addr  <= launch_wr ? wr_addr : apb_req.pwdata[`TXBIST_RAM_AW-1:0];
      acc_wdata <= '{ctl: apb_req.pwdata[7:0], data: {wr_data_hi, wr_data_lo}};
    end
    if (rd_wait & mem_rvalid)
      rd_word <= mem_rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frame_cnt <= '0;
    else if (apb_wr && addr == `TXBIST_REG_FRAME_CNT)
      frame_cnt <= '0;
    else if (eof)
      frame_cnt <= frame_cnt + 1'b1;
  end

  // --------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------
  always_comb
  begin
    cfg.mode     = mode;
    cfg.loop_cnt = loop_cnt;
    cfg.ram_end  = ram_end;
    cfg.prim     = '{ctl: `TXBIST_PRIM_CTL, data: {prim_hi, prim_lo}};
    cfg.idle     = '{ctl: `TXBIST_IDLE_CTL, data: {idle_hi, idle_lo}};
    mem_req.req   = acc_busy;
    mem_req.we    = acc_we;
    mem_req.addr  = acc_addr;
    mem_req.wdata = acc_wdata;
  end

  always_comb
  begin
    // low from launch until the write is granted or read data returns
    apb_rsp.pready  = ~(launch_wr | launch_rd | (acc_busy & ~(mem_gnt & acc_we)) |
                        (rd_wait & ~mem_rvalid));
    apb_rsp.pslverr = 1'b0;
    case (addr)
      `TXBIST_REG_CTRL:       apb_rsp.prdata = apb_word_t'(mode);
      `TXBIST_REG_LOOP_CNT:   apb_rsp.prdata = loop_cnt;
      `TXBIST_REG_RAM_END:    apb_rsp.prdata = apb_word_t'(ram_end);
      `TXBIST_REG_PRIM_LO:    apb_rsp.prdata = prim_lo;
      `TXBIST_REG_PRIM_HI:    apb_rsp.prdata = prim_hi;
      `TXBIST_REG_IDLE_LO:    apb_rsp.prdata = idle_lo;
      `TXBIST_REG_IDLE_HI:    apb_rsp.prdata = idle_hi;
      `TXBIST_REG_WR_ADDR:    apb_rsp.prdata = apb_word_t'(wr_addr);
      `TXBIST_REG_WR_DATA_LO: apb_rsp.prdata = wr_data_lo;
      `TXBIST_REG_WR_DATA_HI: apb_rsp.prdata = wr_data_hi;
      `TXBIST_REG_RD_DATA_LO: apb_rsp.prdata = rd_word.data[31:0];
      `TXBIST_REG_RD_DATA_HI: apb_rsp.prdata = rd_word.data[63:32];
      `TXBIST_REG_RD_CTL:     apb_rsp.prdata = apb_word_t'(rd_word.ctl);
      `TXBIST_REG_FRAME_CNT:  apb_rsp.prdata = frame_cnt;
      default:                apb_rsp.prdata = '0;
    endcase
  end

endmodule

//--- txbist_seq.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module txbist_seq import txbist_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  bist_cfg_t cfg,
  output logic      fetch_req,
  output ram_addr_t fetch_addr,
  input  logic      fetch_gnt,
  input  logic      fetch_rvalid,
  output logic      fifo_clear,
  input  logic      fifo_pop
);

  localparam int CW = $clog2(`TXBIST_FIFO_DEPTH + 1);

  seq_state_e    state;
  loop_cnt_t     passes;     // passes left, 0 runs forever
  logic [CW-1:0] in_flight;  // granted, data not yet in FIFO
  logic [CW-1:0] occupancy;
  logic [CW:0]   credits;
  logic          run;
  logic          last_addr;

  assign run        = (cfg.mode == RAM);
  assign credits    = in_flight + occupancy;
  assign last_addr  = (fetch_addr >= cfg.ram_end);
  assign fifo_clear = (state == SEQ_IDLE);
  assign fetch_req  = (state == SEQ_FETCH) && run && (credits < `TXBIST_FIFO_DEPTH);

  // --------------------------------------------------------------------
  // fetch FSM
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= SEQ_IDLE;
      passes     <= '0;
      fetch_addr <= '0;
    end
    else if (state != SEQ_IDLE && !run)
      state <= SEQ_IDLE;
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          passes <= cfg.loop_cnt;
          if (run)
            state <= SEQ_START;
        end
        SEQ_START:
        begin
          fetch_addr <= '0;
          state      <= SEQ_FETCH;
        end
        SEQ_FETCH:
        begin
          if (fetch_gnt)
          begin
            if (!last_addr)
              fetch_addr <= fetch_addr + 1'b1;
            else
            begin
              fetch_addr <= '0;  // wrap to the start of the pattern
              if (passes != '0)
              begin
                passes <= passes - 1'b1;
                if (passes == 32'd1)
                  state <= SEQ_DONE;
              end
            end
          end
        end
        default: ;  // SEQ_DONE holds until mode leaves RAM
      endcase
    end
  end

  // credit count bounds what can still land in the FIFO
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_flight <= '0;
      occupancy <= '0;
    end
    else if (fifo_clear)
    begin
      in_flight <= '0;
      occupancy <= '0;
    end
    else
    begin
      in_flight <= in_flight + CW'(fetch_gnt) - CW'(fetch_rvalid);
      occupancy <= occupancy + CW'(fetch_rvalid) - CW'(fifo_pop);
    end
  end

endmodule

//--- txbist_top.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module txbist_top import txbist_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output logic     tx_val,
  output tx_word_t tx_word
);

  bist_cfg_t cfg;
  mem_req_t  reg_req;
  logic      reg_gnt;
  logic      reg_rvalid;
  tx_word_t  ram_rdata;
  logic      fetch_req;
  ram_addr_t fetch_addr;
  logic      fetch_gnt;
  logic      fetch_rvalid;
  logic      fifo_clear;
  logic      fifo_pop;
  tx_word_t  fifo_data;
  logic      fifo_empty;
  logic      eof;

  // --------------------------------------------------------------------
  // control and pattern storage
  // --------------------------------------------------------------------
  txbist_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .cfg        (cfg),
    .mem_req    (reg_req),
    .mem_gnt    (reg_gnt),
    .mem_rvalid (reg_rvalid),
    .mem_rdata  (ram_rdata),
    .eof        (eof)
  );

  txbist_mem_arb u_mem_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .reg_req      (reg_req),
    .reg_gnt      (reg_gnt),
    .reg_rvalid   (reg_rvalid),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_gnt    (fetch_gnt),
    .fetch_rvalid (fetch_rvalid),
    .rdata        (ram_rdata)
  );

  // --------------------------------------------------------------------
  // transmit path
  // --------------------------------------------------------------------
  txbist_seq u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_gnt    (fetch_gnt),
    .fetch_rvalid (fetch_rvalid),
    .fifo_clear   (fifo_clear),
    .fifo_pop     (fifo_pop)
  );

  txbist_fifo #(
    .DEPTH (`TXBIST_FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (fifo_clear),
    .push      (fetch_rvalid),  // RAM read data lands here
    .push_data (ram_rdata),
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty)
  );

  txbist_out u_out (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .pop      (fifo_pop),
    .pop_data (fifo_data),
    .empty    (fifo_empty),
    .tx_val   (tx_val),
    .tx_word  (tx_word),
    .eof      (eof)
  );

endmodule

//--- txbist_assert.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module txbist_assert import txbist_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input apb_req_t apb_req,
  input apb_rsp_t apb_rsp,
  input logic     tx_val,
  input tx_word_t tx_word
);

  int   fail_count = 0;
  logic ram_access;

  // access phase of a write that starts a RAM access
  assign ram_access = apb_req.psel & apb_req.penable & apb_req.pwrite &
                      (apb_req.paddr == `TXBIST_REG_WR_CTL ||
                       apb_req.paddr == `TXBIST_REG_RD_ADDR);

  // --------------------------------------------------------------------
  // properties
  // --------------------------------------------------------------------
  pready_high: assert property (@(posedge clk) disable iff (!rst_n)
    !ram_access |-> apb_rsp.pready)
  else
  begin
    fail_count++;
    $error("pready low outside a RAM access");
  end

  no_opcode: assert property (@(posedge clk) disable iff (!rst_n)
    tx_val |-> tx_word.ctl != `TXBIST_REPEAT_OP)
  else
  begin
    fail_count++;
    $error("repeat opcode word reached tx_word");
  end

  val_holds: assert property (@(posedge clk) disable iff (!rst_n)
    tx_val |=> tx_val)  // never drops once up
  else
  begin
    fail_count++;
    $error("tx_val dropped after reset");
  end

endmodule

bind txbist_top txbist_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .tx_val  (tx_val),
  .tx_word (tx_word)
);

//--- tb_txbist.sv
`timescale 1ns/1ns
`include "txbist_cfg.svh"

module tb_txbist import txbist_pkg::*;
();

  typedef struct packed
  {
    bist_mode_e mode;
    loop_cnt_t  loop_cnt;  // 0 runs forever, checked over 3 passes
    int         ram_end;
    int         rpt_pos;   // -1 for none
    int         rpt_cnt;
    int         eof_pos;   // -1 for none
  } row_t;

  localparam int NROWS       = 6;
  localparam int PRIM_CYCLES = 40;

  localparam tx_word_t IDLE_WORD = '{ctl: 8'hFF, data: 64'h0707_0707_0707_0707};
  localparam tx_word_t PRIM_WORD = '{ctl: 8'hFF, data: 64'hA5C3_0F1E_5A3C_E0E1};

  localparam row_t ROWS [NROWS] = '{
    '{DISABLED, 32'd1,  0, -1, 0, -1},
    '{PRIM,     32'd1,  0, -1, 0, -1},
    '{RAM,      32'd1,  7, -1, 0,  7},
    '{RAM,      32'd3,  9,  4, 3,  8},
    '{RAM,      32'd0, 11,  2, 2,  6},
    '{RAM,      32'd2,  3,  1, 5,  3}
  };

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        tx_val;
  tx_word_t    tx_word;
  tx_word_t    image [1 << `TXBIST_RAM_AW];  // copy of what was written to the RAM
  tx_word_t    got_q [$];
  tx_word_t    exp_q [$];
  bit          capture;
  logic [31:0] lcg_state = 32'h1b1a4119;
  int          cycles;
  int          limit;

  txbist_top u_txbist_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .tx_val  (tx_val),
    .tx_word (tx_word)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // cycle budget
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("run exceeded the cycle limit of %0d", limit);
      abort_run();
    end
  end

  // non-idle words on the wire
  always @(negedge clk)
  begin
    if (capture && tx_word != IDLE_WORD)
      got_q.push_back(tx_word);
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic tx_word_t make_word();
    tx_word_t    w;
    logic [31:0] r;
    int          i;
    r     = next_rand();
    w.ctl = r[23:16];
    if (w.ctl == 8'hFF || w.ctl == `TXBIST_REPEAT_OP)
      w.ctl = w.ctl ^ 8'h01;  // never idle, never opcode
    w.data = {next_rand(), next_rand()};
    for (i = 0; i < 8; i++)
    begin
      if (w.data[8*i +: 8] == `TXBIST_EOF_CODE)
        w.data[8*i +: 8] = 8'hFC;
    end
    return w;
  endfunction

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input apb_word_t wdata,
                          output apb_word_t rdata);
    logic ready;
    logic err;
    @(posedge clk);
    apb_req.psel    <= 1'b1;  // setup phase
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    ready = 1'b0;
    while (!ready)
    begin
      @(negedge clk);
      ready = apb_rsp.pready;
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
    end
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    check_value("pslverr", 32'(err), 32'd0);
  endtask

  task automatic apb_write(input logic [7:0] addr, input apb_word_t wdata);
    apb_word_t unused;
    apb_xfer(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output apb_word_t rdata);
    apb_xfer(1'b0, addr, 32'd0, rdata);
  endtask

  task automatic check_value(input string name, input apb_word_t got, input apb_word_t exp);
    assert (got == exp)
    else
    begin
      $display("FAILED %s got %h exp %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input int idx, input tx_word_t got, input tx_word_t exp);
    assert (got == exp)
    else
    begin
      $display("FAILED tx_word[%0d] got %h exp %h", idx, got, exp);
      abort_run();
    end
  endtask

  // fills the RAM through WR_* and reads every word back
  task automatic load_image(input row_t row);
    tx_word_t  w;
    apb_word_t v;
    int        a;
    apb_write(`TXBIST_REG_WR_ADDR, 32'd0);
    for (a = 0; a <= row.ram_end; a++)
    begin
      w = make_word();
      if (a == row.rpt_pos)
        w = '{ctl: `TXBIST_REPEAT_OP, data: 64'(row.rpt_cnt)};
      else if (a == row.eof_pos)
      begin
        w.ctl       = 8'h01;  // K flag on byte 0 only
        w.data[7:0] = `TXBIST_EOF_CODE;
      end
      image[a] = w;
      apb_write(`TXBIST_REG_WR_DATA_LO, w.data[31:0]);
      apb_write(`TXBIST_REG_WR_DATA_HI, w.data[63:32]);
      apb_write(`TXBIST_REG_WR_CTL, 32'(w.ctl));
    end
    for (a = 0; a <= row.ram_end; a++)
    begin
      apb_write(`TXBIST_REG_RD_ADDR, 32'(a));
      apb_read(`TXBIST_REG_RD_DATA_LO, v);
      check_value("RD_DATA_LO", v, image[a].data[31:0]);
      apb_read(`TXBIST_REG_RD_DATA_HI, v);
      check_value("RD_DATA_HI", v, image[a].data[63:32]);
      apb_read(`TXBIST_REG_RD_CTL, v);
      check_value("RD_CTL", v, 32'(image[a].ctl));
    end
  endtask

  // opcode word dropped, word before it sent N more times
  function automatic void build_expected(input row_t row);
    tx_word_t prev;
    int       passes;
    int       p;
    int       a;
    int       n;
    passes = (row.loop_cnt == 0) ? 3 : row.loop_cnt;
    prev   = IDLE_WORD;
    exp_q.delete();
    for (p = 0; p < passes; p++)
    begin
      for (a = 0; a <= row.ram_end; a++)
      begin
        if (image[a].ctl == `TXBIST_REPEAT_OP)
        begin
          for (n = 0; n < image[a].data[31:0]; n++)
            exp_q.push_back(prev);
        end
        else
        begin
          exp_q.push_back(image[a]);
          prev = image[a];
        end
      end
    end
  endfunction

  // --------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------
  initial
  begin
    row_t      row;
    apb_word_t v;
    int        r;
    int        i;
    int        passes;
    int        exp_frames;
    apb_req = '0;
    rst_n   = 1'b0;
    limit   = 2000;
    for (r = 0; r < NROWS; r++)
    begin
      passes = (ROWS[r].loop_cnt == 0) ? 3 : ROWS[r].loop_cnt;
      limit += 4 * (passes * (ROWS[r].ram_end + 1) + 50);
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("tx_val", 32'(tx_val), 32'd0);  // no edge yet since release
    @(negedge clk);
    check_value("tx_val", 32'(tx_val), 32'd1);

    for (r = 0; r < NROWS; r++)
    begin
      row    = ROWS[r];
      passes = (row.loop_cnt == 0) ? 3 : row.loop_cnt;
      exp_q.delete();
      if (row.mode == RAM)
      begin
        load_image(row);
        apb_write(`TXBIST_REG_LOOP_CNT, row.loop_cnt);
        apb_write(`TXBIST_REG_RAM_END, 32'(row.ram_end));
        build_expected(row);
      end
      else if (row.mode == PRIM)
      begin
        apb_write(`TXBIST_REG_PRIM_LO, PRIM_WORD.data[31:0]);
        apb_write(`TXBIST_REG_PRIM_HI, PRIM_WORD.data[63:32]);
      end
      apb_write(`TXBIST_REG_FRAME_CNT, 32'd0);  // clears the count
      got_q.delete();
      capture = 1'b1;
      apb_write(`TXBIST_REG_CTRL, 32'(row.mode));
      if (row.mode == RAM)
      begin
        while (got_q.size() < exp_q.size())
          @(posedge clk);
        if (row.loop_cnt != 0)
          repeat (20) @(posedge clk);  // only idles may follow
      end
      else
        repeat (PRIM_CYCLES) @(posedge clk);
      apb_write(`TXBIST_REG_CTRL, 32'(DISABLED));
      repeat (4) @(posedge clk);
      capture = 1'b0;

      if (row.mode == PRIM)
      begin
        assert (got_q.size() >= PRIM_CYCLES)
        else
        begin
          $display("primitive mode sent only %0d words", got_q.size());
          abort_run();
        end
        for (i = 0; i < got_q.size(); i++)
          check_word(i, got_q[i], PRIM_WORD);
      end
      else
      begin
        if (row.loop_cnt != 0)
          check_value("tx_word count", got_q.size(), exp_q.size());
        for (i = 0; i < exp_q.size(); i++)
          check_word(i, got_q[i], exp_q[i]);
      end

      if (row.loop_cnt != 0)
      begin
        exp_frames = (row.eof_pos >= 0) ? passes : 0;  // one EOF word per pass
        apb_read(`TXBIST_REG_FRAME_CNT, v);
        check_value("FRAME_CNT", v, exp_frames);
      end
    end

    if (u_txbist_top.u_assert.fail_count != 0)
    begin
      $display("bound assertions reported failures");
      abort_run();
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- files.f
+incdir+.
txbist_pkg.sv
txbist_fifo.sv
txbist_mem_arb.sv
txbist_out.sv
txbist_regs.sv
txbist_seq.sv
txbist_top.sv
txbist_assert.sv
tb_txbist.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_txbist -o sim_txbist
./obj_dir/sim_txbist | tee sim.log

if grep -q "Test completed successfully" sim.log
then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
